//--- build.f
+incdir+src
src/alu_types_pkg.sv
src/alu_path_pkg.sv
src/alu_arith.sv
src/alu_acc.sv
src/alu_bitops.sv
src/alu_ctrl.sv
src/alu_top.sv
verif/tb_alu.sv

//--- Bender.yml
package:
  name: alu_q6_10

sources:
  - include_dirs:
      - src
    files:
      - src/alu_types_pkg.sv
      - src/alu_path_pkg.sv
      - src/alu_arith.sv
      - src/alu_acc.sv
      - src/alu_bitops.sv
      - src/alu_ctrl.sv
      - src/alu_top.sv
  - target: test
    files:
      - verif/tb_alu.sv

//--- verif/tb_alu.sv
module tb_alu
    import alu_types_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int N_DIRECTED = 19;
    localparam int N_RANDOM   = 400;
    localparam int N_REQ      = N_DIRECTED + N_RANDOM;
    localparam int ACC_MAX    = 524287;
    localparam int ACC_MIN    = -524288;

    logic      i_clk = 1'b0;
    logic      i_rst_n;
    logic      i_in_valid;
    alu_op_e   i_op;
    alu_data_t i_a;
    alu_data_t i_b;
    logic      o_busy;
    logic      o_out_valid;
    alu_data_t o_data;

    logic [31:0] rng_state;
    longint      model_acc [16];
    int          mismatch_count;
    int          protocol_count;

    alu_top alu_top_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .i_op        (i_op),
        .i_a         (i_a),
        .i_b         (i_b),
        .o_busy      (o_busy),
        .o_out_valid (o_out_valid),
        .o_data      (o_data)
    );

    always #5 i_clk = ~i_clk;

    // ########################################
    // stimulus source and reference model
    // ########################################

    function automatic logic [31:0] next_rand();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // corner values show up often, small values exercise the shifts
    function automatic alu_data_t pick_operand();
        logic [31:0] r;
        r = next_rand();
        case (r[2:0])
            3'd0:    return 16'h7FFF;
            3'd1:    return 16'h8000;
            3'd2:    return 16'h0000;
            3'd3:    return alu_data_t'(r[8:4]);
            default: return r[31:16];
        endcase
    endfunction

    function automatic alu_data_t clamp_word(input longint v);
        if (v > 32767) begin
            return 16'h7FFF;
        end
        if (v < -32768) begin
            return 16'h8000;
        end
        return v[15:0];
    endfunction

    function automatic alu_data_t predict(input alu_op_e op, input alu_data_t a,
                                          input alu_data_t b);
        longint      p;
        logic [15:0] ua;
        int          n;
        ua = a;
        n  = b[3:0];
        case (op)
            OP_SADD: return clamp_word(longint'(a) + longint'(b));
            OP_SSUB: return clamp_word(longint'(a) - longint'(b));
            OP_SMUL: begin
                p = longint'(a) * longint'(b);
                // half an lsb rounds up
                if (p[9]) begin
                    p = p + 1024;
                end
                return clamp_word(p >>> 10);
            end
            OP_SACC: begin
                model_acc[a[3:0]] = model_acc[a[3:0]] + b;
                return clamp_word(model_acc[a[3:0]]);
            end
            OP_XOR:  return a ^ b;
            OP_ARST: begin
                if ($unsigned(b) >= 16) begin
                    return {16{a[15]}};
                end
                return alu_data_t'(longint'(a) >>> n);
            end
            OP_LROT: return (ua << n) | (ua >> (16 - n));
            OP_CLZR: begin
                for (int i = 15; i >= 0; i--) begin
                    if (a[i]) begin
                        return alu_data_t'(15 - i);
                    end
                end
                return 16'd16;
            end
            default: return '0;
        endcase
    endfunction

    // ########################################
    // compare tasks
    // ########################################

    task automatic check_data(input string name, input alu_data_t got,
                              input alu_data_t exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            mismatch_count++;
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("mismatch %s: got 0x%h expected 0x%h at %0t", name, got, exp, $time);
            mismatch_count++;
        end
    endtask

    // one request from the accept edge back to the accept state
    task automatic run_request(input alu_op_e op, input alu_data_t a, input alu_data_t b);
        alu_data_t expected;
        int        edges;
        expected   = predict(op, a, b);
        i_in_valid = 1'b1;
        i_op       = op;
        i_a        = a;
        i_b        = b;
        @(negedge i_clk);
        edges = 1;
        // stray accumulate offered while busy, it must not land
        i_op = OP_SACC;
        i_a  = ~a;
        i_b  = 16'h1234;
        while (!o_out_valid && edges < 4) begin
            check_flag("o_busy", o_busy, 1'b1);
            @(negedge i_clk);
            edges++;
        end
        if (!o_out_valid) begin
            $display("o_out_valid never rose for opcode %s", op.name());
            protocol_count++;
        end else begin
            if (edges != 2) begin
                $display("o_out_valid rose %0d edges after accept instead of 2", edges);
                protocol_count++;
            end
            check_data("o_data", o_data, expected);
            check_flag("o_busy", o_busy, 1'b1);
        end
        @(negedge i_clk);
        i_in_valid = 1'b0;
        check_flag("o_out_valid", o_out_valid, 1'b0);
        check_flag("o_busy", o_busy, 1'b0);
    endtask

    // ########################################
    // main sequence
    // ########################################

    initial begin
        alu_op_e     op;
        alu_data_t   a;
        alu_data_t   b;
        logic [3:0]  code;
        longint      next_sum;
        i_rst_n        = 1'b0;
        i_in_valid     = 1'b0;
        i_op           = OP_SADD;
        i_a            = '0;
        i_b            = '0;
        rng_state      = 32'd75267;
        mismatch_count = 0;
        protocol_count = 0;
        for (int i = 0; i < 16; i++) begin
            model_acc[i] = 0;
        end

        repeat (8) begin
            @(negedge i_clk);
            check_flag("o_busy", o_busy, 1'b1);
            check_flag("o_out_valid", o_out_valid, 1'b0);
        end
        i_rst_n = 1'b1;
        @(negedge i_clk);
        check_flag("o_busy", o_busy, 1'b0);
        check_flag("o_out_valid", o_out_valid, 1'b0);

        // saturation and rounding corners
        run_request(OP_SADD, 16'h7000, 16'h7000);
        run_request(OP_SSUB, 16'h8000, 16'h0001);
        run_request(OP_SMUL, 16'h7FFF, 16'h7FFF);
        run_request(OP_SMUL, 16'h0001, 16'h0200);
        run_request(OP_SMUL, 16'hFC00, 16'h0400);
        // entries 3 and 5 side by side
        run_request(OP_SACC, 16'h0013, 16'h7FFF);
        run_request(OP_SACC, 16'h0013, 16'h7FFF);
        run_request(OP_SACC, 16'h0005, 16'h0010);
        run_request(OP_SACC, 16'h0013, 16'h8000);
        run_request(OP_RSV_SFPS, 16'h0013, 16'h1111);
        run_request(OP_RSV_RMT4, 16'h0013, 16'h2222);
        run_request(OP_SACC, 16'h0003, 16'h0000);
        // negative word shifted inside the word, then past it
        run_request(OP_ARST, 16'h8400, 16'd3);
        run_request(OP_ARST, 16'h8000, 16'd20);
        run_request(OP_ARST, 16'h4000, 16'd16);
        run_request(OP_LROT, 16'h8001, 16'h0011);
        run_request(OP_CLZR, 16'h0000, 16'h0000);
        run_request(OP_CLZR, 16'h0001, 16'h0000);
        run_request(OP_XOR, 16'hA5A5, 16'h0FF0);

        for (int k = 0; k < N_RANDOM; k++) begin
            code = 4'(next_rand() % 10);
            op   = alu_op_e'(code);
            a    = pick_operand();
            b    = pick_operand();
            if (op == OP_SACC) begin
                next_sum = model_acc[a[3:0]] + b;
                // keep the entry inside its 20-bit range
                if (next_sum > ACC_MAX || next_sum < ACC_MIN) begin
                    b = ~b;
                end
            end
            run_request(op, a, b);
        end

        $display("errors: %0d mismatches, %0d protocol failures",
                 mismatch_count, protocol_count);
        if (mismatch_count + protocol_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

    initial begin
        repeat (N_REQ * 10 + 100) @(posedge i_clk);
        $display("timeout: the run did not finish within %0d cycles", N_REQ * 10 + 100);
        $display("Simulation FAILED");
        $finish;
    end

endmodule

//--- src/alu_top.sv
module alu_top
    import alu_types_pkg::*, alu_path_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_in_valid,
    input  alu_op_e   i_op,
    input  alu_data_t i_a,
    input  alu_data_t i_b,
    output logic      o_busy,
    output logic      o_out_valid,
    output alu_data_t o_data
);

    alu_req_t    req;
    logic        acc_en;
    arith_res_t  arith_res;
    bitops_res_t bitops_res;
    alu_data_t   acc_value;

    // controller with operand register and result mux
    alu_ctrl ctrl_inst (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_in_valid  (i_in_valid),
        .i_op        (i_op),
        .i_a         (i_a),
        .i_b         (i_b),
        .i_arith     (arith_res),
        .i_bitops    (bitops_res),
        .i_acc       (acc_value),
        .o_req       (req),
        .o_acc_en    (acc_en),
        .o_busy      (o_busy),
        .o_out_valid (o_out_valid),
        .o_data      (o_data)
    );

    alu_arith arith_inst (
        .i_req (req),
        .o_res (arith_res)
    );

    // the only stateful datapath block
    alu_acc acc_inst (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_acc_en (acc_en),
        .i_req    (req),
        .o_value  (acc_value)
    );

    alu_bitops bitops_inst (
        .i_req (req),
        .o_res (bitops_res)
    );

endmodule

//--- src/alu_ctrl.sv
module alu_ctrl
    import alu_types_pkg::*, alu_path_pkg::*;
(
    input  logic        i_clk,
    input  logic        i_rst_n,
    input  logic        i_in_valid,
    input  alu_op_e     i_op,
    input  alu_data_t   i_a,
    input  alu_data_t   i_b,
    input  arith_res_t  i_arith,
    input  bitops_res_t i_bitops,
    input  alu_data_t   i_acc,
    output alu_req_t    o_req,
    output logic        o_acc_en,
    output logic        o_busy,
    output logic        o_out_valid,
    output alu_data_t   o_data
);

    alu_state_e state;
    alu_state_e next_state;
    alu_req_t   req_q;
    logic       take;

    // ########################################
    // state machine
    // ########################################

    assign take = (state == ST_ACCEPT) && i_in_valid;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            state <= ST_RST;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            ST_RST:     next_state = ST_ACCEPT;
            ST_ACCEPT:  next_state = take ? ST_PROCESS : ST_ACCEPT;
            ST_PROCESS: next_state = ST_DONE;
            ST_DONE:    next_state = ST_ACCEPT;
        endcase
    end

    assign o_busy      = (state != ST_ACCEPT);
    assign o_out_valid = (state == ST_DONE);
    // accumulator write happens on the processing edge only
    assign o_acc_en    = (state == ST_PROCESS) && (req_q.op == OP_SACC);

    // ########################################
    // operand register and result select
    // ########################################

    always_ff @(posedge i_clk) begin
        if (take) begin
            req_q <= '{op: i_op, a: i_a, b: i_b};
        end
    end

    assign o_req = req_q;

    always_comb begin
        case (req_q.op)
            OP_SADD: o_data = i_arith.sum;
            OP_SSUB: o_data = i_arith.diff;
            OP_SMUL: o_data = i_arith.prod;
            OP_SACC: o_data = i_acc;
            OP_XOR:  o_data = i_bitops.xor_v;
            OP_ARST: o_data = i_bitops.sra_v;
            OP_LROT: o_data = i_bitops.rol_v;
            OP_CLZR: o_data = i_bitops.clz_v;
            // reserved and unused codes
            default: o_data = '0;
        endcase
    end

    // a result is never shown while new requests can be taken
    assert property (@(posedge i_clk) disable iff (!i_rst_n) o_out_valid |-> o_busy);

    // processing always takes exactly one cycle
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        (state == ST_PROCESS) |=> (state == ST_DONE));

    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        o_acc_en |-> (state == ST_PROCESS));

endmodule

//--- src/alu_bitops.sv
`include "alu_macros.svh"

module alu_bitops
    import alu_types_pkg::*, alu_path_pkg::*;
(
    input  alu_req_t    i_req,
    output bitops_res_t o_res
);

    localparam int DATA_W  = `ALU_DATA_W;
    localparam int SHAMT_W = $clog2(DATA_W);

    logic [SHAMT_W-1:0]  shamt;
    logic                shift_all;
    logic [2*DATA_W-1:0] rot_pair;

    // leading zeros of a word, 16 for an all-zero input
    function automatic alu_data_t count_lz(input alu_data_t v);
        alu_data_t n;
        logic      seen;
        n    = '0;
        seen = 1'b0;
        for (int i = DATA_W - 1; i >= 0; i--) begin
            if (v[i]) begin
                seen = 1'b1;
            end else if (!seen) begin
                n = n + 1'b1;
            end
        end
        return n;
    endfunction

    assign shamt = i_req.b[SHAMT_W-1:0];
    // any upper bit set means a shift past the word
    assign shift_all = |i_req.b[DATA_W-1:SHAMT_W];

    assign o_res.xor_v = i_req.a ^ i_req.b;

    assign o_res.sra_v = shift_all ? $signed({DATA_W{i_req.a[DATA_W-1]}})
                                   : $signed(i_req.a) >>> shamt;

    // rotate by shifting a doubled copy
    assign rot_pair    = {i_req.a, i_req.a} << shamt;
    assign o_res.rol_v = rot_pair[2*DATA_W-1:DATA_W];

    assign o_res.clz_v = count_lz(i_req.a);

endmodule

//--- src/alu_acc.sv
`include "alu_macros.svh"

module alu_acc
    import alu_types_pkg::*;
(
    input  logic      i_clk,
    input  logic      i_rst_n,
    input  logic      i_acc_en,
    input  alu_req_t  i_req,
    output alu_data_t o_value
);

    localparam int DATA_W = `ALU_DATA_W;
    localparam int ACC_W  = `ALU_ACC_W;
    localparam int DEPTH  = `ALU_ACC_DEPTH;
    localparam int IDX_W  = $clog2(DEPTH);

    alu_acc_t              acc_mem [DEPTH];
    logic [IDX_W-1:0]      idx;
    alu_acc_t              entry;
    logic signed [ACC_W:0] acc_sum;
    logic [ACC_W-DATA_W:0] top;

    // index from the low bits of operand a
    assign idx     = i_req.a[IDX_W-1:0];
    assign entry   = acc_mem[idx];
    assign acc_sum = entry + i_req.b;

    always_ff @(posedge i_clk) begin
        if (!i_rst_n) begin
            for (int i = 0; i < DEPTH; i++) begin
                acc_mem[i] <= '0;
            end
        end else if (i_acc_en) begin
            acc_mem[idx] <= acc_sum[ACC_W-1:0];
        end
    end

    // saturated readout of the indexed entry
    assign top     = entry[ACC_W-1:DATA_W-1];
    assign o_value = ((&top) || !(|top)) ? entry[DATA_W-1:0]
                                         : {entry[ACC_W-1], {(DATA_W-1){~entry[ACC_W-1]}}};

    // the running sum must stay inside the entry width
    assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_acc_en |-> (acc_sum[ACC_W] == acc_sum[ACC_W-1]));

endmodule

//--- src/alu_arith.sv
`include "alu_macros.svh"

module alu_arith
    import alu_types_pkg::*, alu_path_pkg::*;
(
    input  alu_req_t   i_req,
    output arith_res_t o_res
);

    localparam int DATA_W   = `ALU_DATA_W;
    localparam int FRAC_W   = `ALU_FRAC_W;
    localparam int PROD_W   = 2 * DATA_W;
    localparam int SCALED_W = PROD_W - FRAC_W;

    localparam logic signed [PROD_W-1:0] RND_INC = PROD_W'(1) << FRAC_W;

    logic signed [DATA_W:0]     sum_w;
    logic signed [DATA_W:0]     diff_w;
    logic signed [PROD_W-1:0]   prod_full;
    logic signed [PROD_W-1:0]   prod_rnd;
    logic signed [SCALED_W-1:0] prod_scaled;

    // clamp a wide signed value into one word
    function automatic alu_data_t sat_word(input logic signed [SCALED_W-1:0] v);
        logic [SCALED_W-DATA_W:0] top;
        top = v[SCALED_W-1:DATA_W-1];
        if ((&top) || !(|top)) begin
            return v[DATA_W-1:0];
        end
        // max for positive overflow, min for negative
        return {v[SCALED_W-1], {(DATA_W-1){~v[SCALED_W-1]}}};
    endfunction

    // ########################################
    // add and subtract with one guard bit
    // ########################################

    assign sum_w  = i_req.a + i_req.b;
    assign diff_w = i_req.a - i_req.b;

    // ########################################
    // rounded multiply
    // ########################################

    always_comb begin
        prod_full = i_req.a * i_req.b;
        prod_rnd  = prod_full;
        // round up on the first dropped fraction bit
        if (prod_full[FRAC_W-1]) begin
            prod_rnd = prod_full + RND_INC;
        end
        prod_scaled = prod_rnd[PROD_W-1:FRAC_W];
    end

    assign o_res.sum  = sat_word(sum_w);
    assign o_res.diff = sat_word(diff_w);
    assign o_res.prod = sat_word(prod_scaled);

endmodule

//--- src/alu_path_pkg.sv
package alu_path_pkg;

    import alu_types_pkg::*;

    // controller states
    typedef enum logic [1:0] {
        ST_RST     = 2'b00,
        ST_ACCEPT  = 2'b01,
        ST_PROCESS = 2'b10,
        ST_DONE    = 2'b11
    } alu_state_e;

    // saturated results of the arithmetic block
    typedef struct packed {
        alu_data_t sum;
        alu_data_t diff;
        alu_data_t prod;
    } arith_res_t;

    // results of the bit manipulation block
    typedef struct packed {
        alu_data_t xor_v;
        alu_data_t sra_v;
        alu_data_t rol_v;
        alu_data_t clz_v;
    } bitops_res_t;

endpackage

//--- src/alu_types_pkg.sv
`include "alu_macros.svh"

package alu_types_pkg;

    // one Q6.10 word
    typedef logic signed [`ALU_DATA_W-1:0] alu_data_t;

    // one accumulator entry, wider than the word to absorb partial overflow
    typedef logic signed [`ALU_ACC_W-1:0] alu_acc_t;

    // opcodes, reserved codes return zero
    typedef enum logic [`ALU_OP_W-1:0] {
        OP_SADD     = 4'd0,
        OP_SSUB     = 4'd1,
        OP_SMUL     = 4'd2,
        OP_SACC     = 4'd3,
        OP_RSV_SFPS = 4'd4,
        OP_XOR      = 4'd5,
        OP_ARST     = 4'd6,
        OP_LROT     = 4'd7,
        OP_CLZR     = 4'd8,
        OP_RSV_RMT4 = 4'd9
    } alu_op_e;

    // one request as held in the operand register
    typedef struct packed {
        alu_op_e   op;
        alu_data_t a;
        alu_data_t b;
    } alu_req_t;

endpackage

//--- src/alu_macros.svh
`ifndef ALU_MACROS_SVH
`define ALU_MACROS_SVH

// ########################################
// word format, Q6.10 signed
// ########################################

// data word width
`define ALU_DATA_W 16

// fraction bits of the Q6.10 word
`define ALU_FRAC_W 10

// ########################################
// opcode and accumulator bank
// ########################################

// opcode width
`define ALU_OP_W 4

// number of accumulator entries
`define ALU_ACC_DEPTH 16

// width of one accumulator entry
`define ALU_ACC_W 20

`endif
